// File: logic/stream_fanout_defs.svh
`ifndef STREAM_FANOUT_DEFS_SVH
`define STREAM_FANOUT_DEFS_SVH

// byte stream, one byte per beat
`define STREAM_DATA_W 8

// number of fan-out ports
`define PORT_COUNT 4

// longest frame let through by the ingress, in beats
`define MAX_FRAME_LEN 16

`endif

// File: logic/stream_pkg.sv
package stream_pkg;

    // ingress length policing
    // st_idle     between frames, count is zero
    // st_body     inside a frame, counting beats
    // st_discard  tail of an overlong frame, swallowed
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_body    = 2'd1,
        st_discard = 2'd2
    } ingress_state_t;

endpackage

// File: logic/egress_pkg.sv
package egress_pkg;

    // per-port mode, sampled on the first beat of a frame
    typedef enum logic [1:0] {
        op_pass = 2'd0,
        op_drop = 2'd1,
        op_mark = 2'd2
    } egress_op_t;

    // egress frame tracking
    typedef enum logic {
        eg_idle  = 1'b0,
        eg_frame = 1'b1
    } egress_state_t;

endpackage

// File: logic/frame_ingress.sv
`timescale 1ns/1ps

`include "stream_fanout_defs.svh"

module frame_ingress
    import stream_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // upstream byte stream
    input  logic [`STREAM_DATA_W-1:0] in_tdata,
    input  logic                      in_tvalid,
    output logic                      in_tready,
    input  logic                      in_tlast,
    input  logic                      in_tuser,

    // towards the broadcaster
    output logic [`STREAM_DATA_W-1:0] bc_tdata,
    output logic                      bc_tvalid,
    input  logic                      bc_tready,
    output logic                      bc_tlast,
    output logic                      bc_tuser
);

    localparam int cnt_w = $clog2(`MAX_FRAME_LEN + 1);

    ingress_state_t   state;
    ingress_state_t   state_next;
    logic [cnt_w-1:0] beat_cnt;
    logic [cnt_w-1:0] beat_cnt_next;
    logic             in_xfer;
    logic             at_limit;
    logic             cut_beat;

    // discard swallows input, else ready comes straight from downstream
    assign in_tready = (state == st_discard) ? 1'b1 : bc_tready;
    assign bc_tvalid = in_tvalid && (state != st_discard);
    assign in_xfer   = in_tvalid && in_tready;

    // beat_cnt holds beats already sent in this frame
    assign at_limit = (beat_cnt == cnt_w'(`MAX_FRAME_LEN - 1));
    // last allowed beat of a frame that would go on
    assign cut_beat = at_limit && !in_tlast && (state != st_discard);

    assign bc_tdata = in_tdata;
    // forced end of frame carries the error mark
    assign bc_tlast = in_tlast || cut_beat;
    assign bc_tuser = in_tuser || cut_beat;

    always_comb begin
        state_next    = state;
        beat_cnt_next = beat_cnt;
        case (state)
            st_idle, st_body: begin
                if (in_xfer) begin
                    if (in_tlast) begin
                        // normal end of frame
                        state_next    = st_idle;
                        beat_cnt_next = '0;
                    end else if (at_limit) begin
                        // limit reached, drop whatever follows
                        state_next    = st_discard;
                        beat_cnt_next = '0;
                    end else begin
                        state_next    = st_body;
                        beat_cnt_next = beat_cnt + 1'b1;
                    end
                end
            end
            st_discard: begin
                // wait for the real tlast of the overlong frame
                if (in_xfer && in_tlast) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next    = st_idle;
                beat_cnt_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            beat_cnt <= '0;
        end else begin
            state    <= state_next;
            beat_cnt <= beat_cnt_next;
        end
    end

    // count stays within the frame limit
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        beat_cnt <= cnt_w'(`MAX_FRAME_LEN));

    // once a cut beat has gone out, nothing more of that frame is offered
    a_cut_discard: assert property (@(posedge clk) disable iff (rst)
        (bc_tvalid && bc_tready && cut_beat) |=> (state == st_discard && !bc_tvalid));

endmodule

// File: logic/axis_broadcast.sv
`timescale 1ns/1ps

`include "stream_fanout_defs.svh"

module axis_broadcast #(
    parameter int m_count = `PORT_COUNT
) (
    input  logic                      clk,
    input  logic                      rst,

    // single input stream
    input  logic [`STREAM_DATA_W-1:0] s_tdata,
    input  logic                      s_tvalid,
    output logic                      s_tready,
    input  logic                      s_tlast,
    input  logic                      s_tuser,

    // shared payload, one valid and ready per port
    output logic [`STREAM_DATA_W-1:0] m_tdata,
    output logic [m_count-1:0]        m_tvalid,
    input  logic [m_count-1:0]        m_tready,
    output logic                      m_tlast,
    output logic                      m_tuser
);

    logic                      s_tready_reg;
    logic                      s_tready_early;

    // output stage
    logic [`STREAM_DATA_W-1:0] m_tdata_reg;
    logic                      m_tlast_reg;
    logic                      m_tuser_reg;
    logic [m_count-1:0]        m_tvalid_reg;
    logic [m_count-1:0]        m_tvalid_next;

    // overflow slot, catches the beat taken while ready was still high
    logic [`STREAM_DATA_W-1:0] temp_tdata_reg;
    logic                      temp_tlast_reg;
    logic                      temp_tuser_reg;
    logic                      temp_tvalid_reg;
    logic                      temp_tvalid_next;

    logic                      store_in_to_out;
    logic                      store_in_to_temp;
    logic                      store_temp_to_out;
    logic                      all_accepted;
    logic                      out_empty;

    assign s_tready = s_tready_reg;
    assign m_tdata  = m_tdata_reg;
    assign m_tvalid = m_tvalid_reg;
    assign m_tlast  = m_tlast_reg;
    assign m_tuser  = m_tuser_reg;

    // every port still holding the beat takes it this cycle
    assign all_accepted = ((m_tready & m_tvalid_reg) == m_tvalid_reg);
    assign out_empty    = (m_tvalid_reg == '0);

    // ready for next cycle: output drains now, or temp stays empty anyway
    assign s_tready_early = all_accepted ||
                            (!temp_tvalid_reg && (out_empty || !s_tvalid));

    always_comb begin
        // ports that accepted drop their valid
        m_tvalid_next     = m_tvalid_reg & ~m_tready;
        temp_tvalid_next  = temp_tvalid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (s_tready_reg) begin
            if (all_accepted || out_empty) begin
                // straight into the output register
                m_tvalid_next   = {m_count{s_tvalid}};
                store_in_to_out = 1'b1;
            end else begin
                // output busy, park the beat
                temp_tvalid_next = s_tvalid;
                store_in_to_temp = 1'b1;
            end
        end else if (all_accepted) begin
            // input held off, move parked beat forward
            m_tvalid_next     = {m_count{temp_tvalid_reg}};
            temp_tvalid_next  = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_tready_reg    <= 1'b0;
            m_tvalid_reg    <= '0;
            temp_tvalid_reg <= 1'b0;
        end else begin
            s_tready_reg    <= s_tready_early;
            m_tvalid_reg    <= m_tvalid_next;
            temp_tvalid_reg <= temp_tvalid_next;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_tdata_reg <= s_tdata;
            m_tlast_reg <= s_tlast;
            m_tuser_reg <= s_tuser;
        end else if (store_temp_to_out) begin
            m_tdata_reg <= temp_tdata_reg;
            m_tlast_reg <= temp_tlast_reg;
            m_tuser_reg <= temp_tuser_reg;
        end

        if (store_in_to_temp) begin
            temp_tdata_reg <= s_tdata;
            temp_tlast_reg <= s_tlast;
            temp_tuser_reg <= s_tuser;
        end
    end

    // a real beat never lands on top of a parked one
    a_temp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        (store_in_to_temp && s_tvalid) |-> !temp_tvalid_reg);

    // a port still waiting sees the same beat next cycle
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (|(m_tvalid & ~m_tready)) |=>
            ($stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser)));

endmodule

// File: logic/port_egress.sv
`timescale 1ns/1ps

`include "stream_fanout_defs.svh"

module port_egress
    import egress_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  egress_op_t                mode,

    // from the broadcaster, this port's lane
    input  logic [`STREAM_DATA_W-1:0] fan_tdata,
    input  logic                      fan_tvalid,
    output logic                      fan_tready,
    input  logic                      fan_tlast,
    input  logic                      fan_tuser,

    // port output
    output logic [`STREAM_DATA_W-1:0] out_tdata,
    output logic                      out_tvalid,
    input  logic                      out_tready,
    output logic                      out_tlast,
    output logic                      out_tuser
);

    egress_state_t state;
    egress_op_t    op_q;
    egress_op_t    cur_op;
    logic          first_beat;
    logic          dropping;
    logic          fan_xfer;

    // live mode on the first beat, latched one for the rest
    assign first_beat = (state == eg_idle);
    assign cur_op     = first_beat ? mode : op_q;
    assign dropping   = (cur_op == op_drop);

    // drop consumes beats without showing them
    assign fan_tready = dropping ? 1'b1 : out_tready;
    assign out_tvalid = fan_tvalid && !dropping;
    assign fan_xfer   = fan_tvalid && fan_tready;

    assign out_tdata = fan_tdata;
    assign out_tlast = fan_tlast;
    // mark sets tuser on the head beat only
    assign out_tuser = fan_tuser || (first_beat && cur_op == op_mark);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= eg_idle;
            op_q  <= op_pass;
        end else if (fan_xfer) begin
            if (first_beat) begin
                op_q <= mode;
                // single-beat frame keeps us idle
                if (!fan_tlast) begin
                    state <= eg_frame;
                end
            end else if (fan_tlast) begin
                state <= eg_idle;
            end
        end
    end

    // a dropped frame stays hidden up to its last beat, whatever mode does
    a_drop_hidden: assert property (@(posedge clk) disable iff (rst)
        (fan_xfer && first_beat && mode == op_drop && !fan_tlast) |=>
            (!out_tvalid until_with (fan_tvalid && fan_tlast)));

endmodule

// File: logic/stream_fanout.sv
`timescale 1ns/1ps

`include "stream_fanout_defs.svh"

module stream_fanout
    import egress_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,

    // input stream
    input  logic [`STREAM_DATA_W-1:0]                   in_tdata,
    input  logic                                        in_tvalid,
    output logic                                        in_tready,
    input  logic                                        in_tlast,
    input  logic                                        in_tuser,

    // per-port outputs
    output logic [`PORT_COUNT-1:0][`STREAM_DATA_W-1:0]  out_tdata,
    output logic [`PORT_COUNT-1:0]                      out_tvalid,
    input  logic [`PORT_COUNT-1:0]                      out_tready,
    output logic [`PORT_COUNT-1:0]                      out_tlast,
    output logic [`PORT_COUNT-1:0]                      out_tuser,

    // per-port mode level
    input  egress_op_t                                  mode [`PORT_COUNT]
);

    // policed stream into the broadcaster
    logic [`STREAM_DATA_W-1:0] bc_tdata;
    logic                      bc_tvalid;
    logic                      bc_tready;
    logic                      bc_tlast;
    logic                      bc_tuser;

    // broadcast lanes, payload shared across ports
    logic [`STREAM_DATA_W-1:0] fan_tdata;
    logic [`PORT_COUNT-1:0]    fan_tvalid;
    logic [`PORT_COUNT-1:0]    fan_tready;
    logic                      fan_tlast;
    logic                      fan_tuser;

    frame_ingress i_frame_ingress (
        .clk       (clk),
        .rst       (rst),
        .in_tdata  (in_tdata),
        .in_tvalid (in_tvalid),
        .in_tready (in_tready),
        .in_tlast  (in_tlast),
        .in_tuser  (in_tuser),
        .bc_tdata  (bc_tdata),
        .bc_tvalid (bc_tvalid),
        .bc_tready (bc_tready),
        .bc_tlast  (bc_tlast),
        .bc_tuser  (bc_tuser)
    );

    axis_broadcast #(
        .m_count (`PORT_COUNT)
    ) i_axis_broadcast (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (bc_tdata),
        .s_tvalid (bc_tvalid),
        .s_tready (bc_tready),
        .s_tlast  (bc_tlast),
        .s_tuser  (bc_tuser),
        .m_tdata  (fan_tdata),
        .m_tvalid (fan_tvalid),
        .m_tready (fan_tready),
        .m_tlast  (fan_tlast),
        .m_tuser  (fan_tuser)
    );

    // one egress per port
    for (genvar i = 0; i < `PORT_COUNT; i++) begin : g_egress
        port_egress i_port_egress (
            .clk        (clk),
            .rst        (rst),
            .mode       (mode[i]),
            .fan_tdata  (fan_tdata),
            .fan_tvalid (fan_tvalid[i]),
            .fan_tready (fan_tready[i]),
            .fan_tlast  (fan_tlast),
            .fan_tuser  (fan_tuser),
            .out_tdata  (out_tdata[i]),
            .out_tvalid (out_tvalid[i]),
            .out_tready (out_tready[i]),
            .out_tlast  (out_tlast[i]),
            .out_tuser  (out_tuser[i])
        );
    end

endmodule

// File: tests/stream_fanout_tb.sv
`timescale 1ns/1ps

`include "stream_fanout_defs.svh"

module stream_fanout_tb
    import egress_pkg::*;
();

    localparam int n_ports   = `PORT_COUNT;
    localparam int data_w    = `STREAM_DATA_W;
    localparam int beat_w    = data_w + 2;
    localparam int n_entries = 11;

    logic                          clk;
    logic                          rst;
    logic [data_w-1:0]             in_tdata;
    logic                          in_tvalid;
    logic                          in_tready;
    logic                          in_tlast;
    logic                          in_tuser;
    logic [n_ports-1:0][data_w-1:0] out_tdata;
    logic [n_ports-1:0]            out_tvalid;
    logic [n_ports-1:0]            out_tready;
    logic [n_ports-1:0]            out_tlast;
    logic [n_ports-1:0]            out_tuser;
    egress_op_t                    mode [n_ports];

    // frame table
    string      tbl_name [n_entries];
    int         tbl_len  [n_entries];
    logic       tbl_user [n_entries];
    egress_op_t tbl_mode [n_entries][n_ports];
    int         tbl_bp   [n_entries];

    // expected beats per port, packed as {tlast, tuser, tdata}
    logic [beat_w-1:0] exp_q [n_ports][$];

    string             cur_name;
    int                bp_pct;
    int                errors;
    int                checks;
    int                cycles;
    int                timeout_limit = 1000000;
    logic [data_w-1:0] payload;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    stream_fanout i_stream_fanout (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .in_tuser   (in_tuser),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser),
        .mode       (mode)
    );

    task automatic set_entry(input int idx, input string name, input int len,
                             input logic user, input egress_op_t m0, input egress_op_t m1,
                             input egress_op_t m2, input egress_op_t m3, input int pct);
        tbl_name[idx]    = name;
        tbl_len[idx]     = len;
        tbl_user[idx]    = user;
        tbl_mode[idx][0] = m0;
        tbl_mode[idx][1] = m1;
        tbl_mode[idx][2] = m2;
        tbl_mode[idx][3] = m3;
        tbl_bp[idx]      = pct;
    endtask

    task automatic load_table();
        // plain pass with no back-pressure
        set_entry(0, "pass_short", 4, 1'b0, op_pass, op_pass, op_pass, op_pass, 0);
        set_entry(1, "pass_single", 1, 1'b1, op_pass, op_pass, op_pass, op_pass, 0);
        set_entry(2, "pass_full", 16, 1'b0, op_pass, op_pass, op_pass, op_pass, 0);
        // cut at the limit with a normal frame right behind
        set_entry(3, "overlong", 22, 1'b0, op_pass, op_pass, op_pass, op_pass, 0);
        set_entry(4, "after_cut", 5, 1'b0, op_pass, op_pass, op_pass, op_pass, 0);
        // mixed modes
        set_entry(5, "mixed_modes", 6, 1'b0, op_pass, op_drop, op_mark, op_pass, 0);
        set_entry(6, "mark_single", 1, 1'b0, op_mark, op_mark, op_drop, op_pass, 0);
        // random back-pressure per port
        set_entry(7, "bp_light", 9, 1'b1, op_pass, op_pass, op_pass, op_pass, 30);
        set_entry(8, "bp_heavy", 12, 1'b0, op_pass, op_mark, op_pass, op_drop, 70);
        set_entry(9, "bp_overlong", 20, 1'b0, op_mark, op_pass, op_drop, op_pass, 50);
        set_entry(10, "bp_tail", 3, 1'b0, op_pass, op_pass, op_pass, op_pass, 60);
    endtask

    // reference model applies truncation before the per-port opcode
    task automatic push_expected(input int idx, input logic [data_w-1:0] base);
        int                kept;
        logic              cut;
        logic [data_w-1:0] data;
        logic              last;
        logic              user;
        cut  = (tbl_len[idx] > `MAX_FRAME_LEN);
        kept = cut ? `MAX_FRAME_LEN : tbl_len[idx];
        for (int p = 0; p < n_ports; p++) begin
            if (tbl_mode[idx][p] != op_drop) begin
                for (int b = 0; b < kept; b++) begin
                    data = base + data_w'(b);
                    last = (b == kept - 1);
                    // error mark rides on the forced last beat
                    user = ((b == 0) && tbl_user[idx]) || (cut && last);
                    if ((b == 0) && (tbl_mode[idx][p] == op_mark)) begin
                        user = 1'b1;
                    end
                    exp_q[p].push_back({last, user, data});
                end
            end
        end
    endtask

    // one beat per handshake with a running byte counter as payload
    task automatic send_frame(input int idx);
        for (int b = 0; b < tbl_len[idx]; b++) begin
            in_tdata  <= payload;
            in_tvalid <= 1'b1;
            in_tlast  <= (b == tbl_len[idx] - 1);
            in_tuser  <= (b == 0) ? tbl_user[idx] : 1'b0;
            payload = payload + 1'b1;
            @(posedge clk);
            while (!in_tready) begin
                @(posedge clk);
            end
        end
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
        in_tuser  <= 1'b0;
    endtask

    function automatic logic queues_empty();
        logic empty;
        empty = 1'b1;
        for (int p = 0; p < n_ports; p++) begin
            if (exp_q[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    // wait until every port has drained its frame
    task automatic wait_drain();
        while (!queues_empty()) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic check_reset();
        repeat (3) @(posedge clk);
        @(posedge clk);
        checks++;
        assert (out_tvalid == '0) else begin
            errors++;
            $display("CHECK FAILED reset out_tvalid expected 0 actual %b", out_tvalid);
        end
        rst <= 1'b0;
        // input still held off in the first cycle out of reset
        @(posedge clk);
        checks += 2;
        assert (in_tready == 1'b0) else begin
            errors++;
            $display("CHECK FAILED reset in_tready expected 0 actual %b", in_tready);
        end
        assert (out_tvalid == '0) else begin
            errors++;
            $display("CHECK FAILED reset out_tvalid expected 0 actual %b", out_tvalid);
        end
        @(posedge clk);
        checks++;
        assert (in_tready == 1'b1) else begin
            errors++;
            $display("CHECK FAILED reset in_tready expected 1 actual %b", in_tready);
        end
    endtask

    // independent random ready per port
    initial begin
        void'($urandom(20));
        forever begin
            @(posedge clk);
            for (int p = 0; p < n_ports; p++) begin
                out_tready[p] <= (int'($urandom % 100) >= bp_pct);
            end
        end
    end

    // scoreboard checks every accepted output beat against the model
    always @(posedge clk) begin : scoreboard
        logic [beat_w-1:0] exp_beat;
        logic [beat_w-1:0] got_beat;
        if (!rst) begin
            for (int p = 0; p < n_ports; p++) begin
                if (out_tvalid[p] && out_tready[p]) begin
                    got_beat = {out_tlast[p], out_tuser[p], out_tdata[p]};
                    checks++;
                    assert (exp_q[p].size() > 0) else begin
                        errors++;
                        $display("ERROR: %s port %0d delivered a beat nobody expected (%h)",
                                 cur_name, p, got_beat);
                    end
                    if (exp_q[p].size() > 0) begin
                        exp_beat = exp_q[p].pop_front();
                        assert (got_beat === exp_beat) else begin
                            errors++;
                            $display("CHECK FAILED %s port %0d expected %h actual %h",
                                     cur_name, p, exp_beat, got_beat);
                        end
                    end
                end
            end
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("ERROR: run hung, no finish after %0d cycles", cycles);
            $display("checks=%0d errors=%0d", checks, errors + 1);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int total;
        rst        = 1'b1;
        in_tdata   = '0;
        in_tvalid  = 1'b0;
        in_tlast   = 1'b0;
        in_tuser   = 1'b0;
        out_tready = '0;
        for (int p = 0; p < n_ports; p++) begin
            mode[p] = op_pass;
        end
        bp_pct   = 0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        payload  = '0;
        cur_name = "reset";
        load_table();
        total = 0;
        for (int i = 0; i < n_entries; i++) begin
            total += tbl_len[i];
        end
        timeout_limit = total * 20 + 100;

        check_reset();

        for (int i = 0; i < n_entries; i++) begin
            // nothing in flight here so modes may switch
            cur_name = tbl_name[i];
            for (int p = 0; p < n_ports; p++) begin
                mode[p] <= tbl_mode[i][p];
            end
            bp_pct <= tbl_bp[i];
            push_expected(i, payload);
            send_frame(i);
            wait_drain();
        end

        for (int p = 0; p < n_ports; p++) begin
            checks++;
            assert (exp_q[p].size() == 0) else begin
                errors++;
                $display("ERROR: port %0d still owes %0d beats", p, exp_q[p].size());
            end
        end

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: stream_fanout.f
+incdir+logic
logic/stream_pkg.sv
logic/egress_pkg.sv
logic/frame_ingress.sv
logic/axis_broadcast.sv
logic/port_egress.sv
logic/stream_fanout.sv
tests/stream_fanout_tb.sv
